// File: design/alu.sv
`timescale 1ns/100ps

module alu
    import rv32_pkg::*;
(
    input  logic [3:0]      op_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    output logic [XLEN-1:0] y_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];  // only low five bits shift

    always_comb begin
        case (op_i)
            ALU_ADD:   y_o = a_i + b_i;
            ALU_SUB:   y_o = a_i - b_i;
            ALU_AND:   y_o = a_i & b_i;
            ALU_OR:    y_o = a_i | b_i;
            ALU_XOR:   y_o = a_i ^ b_i;
            ALU_SLT:   y_o = {{(XLEN-1){1'b0}}, ($signed(a_i) < $signed(b_i))};
            ALU_SLTU:  y_o = {{(XLEN-1){1'b0}}, (a_i < b_i)};
            ALU_SLL:   y_o = a_i << shamt;
            ALU_SRL:   y_o = a_i >> shamt;
            ALU_SRA:   y_o = $unsigned($signed(a_i) >>> shamt);
            ALU_PASSB: y_o = b_i;
            default:   y_o = '0;
        endcase
    end

endmodule

// File: design/decode_stage.sv
`timescale 1ns/100ps

module decode_stage
    import rv32_pkg::*;
(
    input  logic            clk,
    input  logic            reset_i,
    input  logic            stall_i,
    input  logic [XLEN-1:0] imem_data_i,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    output logic [XLEN-1:0] imem_addr_o,
    output logic [4:0]      rs1_addr_o,
    output logic [4:0]      rs2_addr_o,
    output logic            ex_valid_o,
    output logic [4:0]      ex_rd_o,
    output logic [4:0]      ex_rs1_o,
    output logic [4:0]      ex_rs2_o,
    output logic [XLEN-1:0] ex_a_o,
    output logic [XLEN-1:0] ex_b_o,
    output logic [XLEN-1:0] ex_imm_o,
    output logic [3:0]      ex_alu_op_o,
    output logic            ex_use_imm_o,
    output logic            ex_mem_rd_o,
    output logic            ex_mem_wr_o,
    output logic            ex_reg_wr_o,
    output logic [XLEN-1:0] ex_pc_o
);

    logic [XLEN-1:0] pc;
    rv32_instr_u     instr;
    logic [XLEN-1:0] imm;
    logic [3:0]      alu_op;
    logic            use_imm;
    logic            mem_rd;
    logic            mem_wr;
    logic            reg_wr;
    logic            a_is_pc;
    logic            use_rs1;
    logic            use_rs2;

    // funct3 to ALU op, alt is instruction bit 30
    function automatic logic [3:0] alu_decode(input logic [2:0] f3, input logic alt,
                                              input logic is_reg);
        case (f3)
            F3_ADD:  return (is_reg && alt) ? ALU_SUB : ALU_ADD;  // no subi
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign imem_addr_o = pc;
    assign instr       = imem_data_i;
    assign rs1_addr_o  = instr.r.rs1;
    assign rs2_addr_o  = instr.r.rs2;

    always_comb begin
        imm     = {{20{instr.i.imm[11]}}, instr.i.imm};  // I format by default
        alu_op  = ALU_ADD;
        use_imm = 1'b1;
        mem_rd  = 1'b0;
        mem_wr  = 1'b0;
        reg_wr  = 1'b0;
        a_is_pc = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (instr.r.opcode)
            OP_REG: begin
                alu_op  = alu_decode(instr.r.funct3, instr.r.funct7[5], 1'b1);
                use_imm = 1'b0;
                reg_wr  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            OP_IMM: begin
                alu_op  = alu_decode(instr.i.funct3, instr.r.funct7[5], 1'b0);
                reg_wr  = 1'b1;
                use_rs1 = 1'b1;
            end
            OP_LUI: begin
                imm    = {instr.u.imm, 12'b0};
                alu_op = ALU_PASSB;
                reg_wr = 1'b1;
            end
            OP_AUIPC: begin
                imm     = {instr.u.imm, 12'b0};
                a_is_pc = 1'b1;
                reg_wr  = 1'b1;
            end
            OP_LOAD: begin
                mem_rd  = 1'b1;
                reg_wr  = 1'b1;
                use_rs1 = 1'b1;
            end
            OP_STORE: begin
                imm     = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
                mem_wr  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            default: ;  // retires as a no-op
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc         <= RESET_PC;
            ex_valid_o <= 1'b0;
        end else if (!stall_i) begin
            pc         <= pc + XLEN'(4);  // no branches, always sequential
            ex_valid_o <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            ex_rd_o      <= reg_wr ? instr.r.rd : 5'd0;
            ex_rs1_o     <= use_rs1 ? instr.r.rs1 : 5'd0;  // zero index blocks forwarding
            ex_rs2_o     <= use_rs2 ? instr.r.rs2 : 5'd0;
            ex_a_o       <= a_is_pc ? pc : rs1_data_i;
            ex_b_o       <= rs2_data_i;
            ex_imm_o     <= imm;
            ex_alu_op_o  <= alu_op;
            ex_use_imm_o <= use_imm;
            ex_mem_rd_o  <= mem_rd;
            ex_mem_wr_o  <= mem_wr;
            ex_reg_wr_o  <= reg_wr;
            ex_pc_o      <= pc;
        end
    end

endmodule

// File: design/execute_stage.sv
`timescale 1ns/100ps

module execute_stage
    import rv32_pkg::*;
(
    input  logic            clk,
    input  logic            reset_i,
    input  logic            ex_valid_i,
    input  logic [4:0]      ex_rd_i,
    input  logic [4:0]      ex_rs1_i,
    input  logic [4:0]      ex_rs2_i,
    input  logic [XLEN-1:0] ex_a_i,
    input  logic [XLEN-1:0] ex_b_i,
    input  logic [XLEN-1:0] ex_imm_i,
    input  logic [3:0]      ex_alu_op_i,
    input  logic            ex_use_imm_i,
    input  logic            ex_mem_rd_i,
    input  logic            ex_mem_wr_i,
    input  logic            ex_reg_wr_i,
    input  logic [XLEN-1:0] ex_pc_i,
    input  logic            fwd_valid_i,
    input  logic [4:0]      fwd_rd_i,
    input  logic [XLEN-1:0] fwd_data_i,
    input  logic            dmem_resp_i,
    input  logic [XLEN-1:0] dmem_rdata_i,
    output logic            stall_o,
    output logic            dmem_req_o,
    output logic            dmem_we_o,
    output logic [XLEN-1:0] dmem_addr_o,
    output logic [XLEN-1:0] dmem_wdata_o,
    output logic            res_valid_o,
    output logic [4:0]      res_rd_o,
    output logic            res_reg_wr_o,
    output logic [XLEN-1:0] res_data_o,
    output logic [XLEN-1:0] res_pc_o
);

    logic            fwd_a;
    logic            fwd_b;
    logic [XLEN-1:0] a_val;
    logic [XLEN-1:0] b_val;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_y;

    assign fwd_a = fwd_valid_i && (fwd_rd_i != 5'd0) && (fwd_rd_i == ex_rs1_i);
    assign fwd_b = fwd_valid_i && (fwd_rd_i != 5'd0) && (fwd_rd_i == ex_rs2_i);
    assign a_val = fwd_a ? fwd_data_i : ex_a_i;
    assign b_val = fwd_b ? fwd_data_i : ex_b_i;
    assign alu_b = ex_use_imm_i ? ex_imm_i : b_val;

    alu u_alu (
        .op_i (ex_alu_op_i),
        .a_i  (a_val),
        .b_i  (alu_b),
        .y_o  (alu_y)
    );

    assign dmem_req_o   = ex_valid_i && (ex_mem_rd_i || ex_mem_wr_i);
    assign dmem_we_o    = ex_mem_wr_i;
    assign dmem_addr_o  = alu_y;  // rs1 + offset
    assign dmem_wdata_o = b_val;
    assign stall_o      = dmem_req_o && !dmem_resp_i;  // wait for the response

    always_ff @(posedge clk) begin
        if (reset_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= ex_valid_i && !stall_o;  // bubble while waiting
        end
    end

    always_ff @(posedge clk) begin
        res_rd_o     <= ex_rd_i;
        res_reg_wr_o <= ex_reg_wr_i;
        res_data_o   <= ex_mem_rd_i ? dmem_rdata_i : alu_y;
        res_pc_o     <= ex_pc_i;
    end

endmodule

// File: design/register_file.sv
`timescale 1ns/100ps

module register_file
    import rv32_pkg::*;
(
    input  logic            clk,
    input  logic            reset_i,
    input  logic [4:0]      rs1_addr_i,
    input  logic [4:0]      rs2_addr_i,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o,
    input  logic            we_i,
    input  logic [4:0]      rd_addr_i,
    input  logic [XLEN-1:0] rd_data_i
);

    logic [XLEN-1:0] regs [0:31];
    logic            wr_live;

    assign wr_live = we_i && (rd_addr_i != 5'd0);  // x0 never written

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_live) begin
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    // same-cycle write passes straight through
    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 :
                        (wr_live && rd_addr_i == rs1_addr_i) ? rd_data_i : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 :
                        (wr_live && rd_addr_i == rs2_addr_i) ? rd_data_i : regs[rs2_addr_i];

endmodule

// File: design/result_stage.sv
`timescale 1ns/100ps

module result_stage
    import rv32_pkg::*;
(
    input  logic            clk,
    input  logic            reset_i,
    input  logic            res_valid_i,
    input  logic [4:0]      res_rd_i,
    input  logic            res_reg_wr_i,
    input  logic [XLEN-1:0] res_data_i,
    input  logic [XLEN-1:0] res_pc_i,
    output logic            rf_we_o,
    output logic [4:0]      rf_addr_o,
    output logic [XLEN-1:0] rf_data_o,
    output logic            fwd_valid_o,
    output logic [4:0]      fwd_rd_o,
    output logic [XLEN-1:0] fwd_data_o,
    output logic            wb_valid_o,
    output logic [4:0]      wb_rd_o,
    output logic [XLEN-1:0] wb_data_o,
    output logic [XLEN-1:0] wb_pc_o
);

    logic            write;
    logic            last_valid;
    logic [4:0]      last_rd;
    logic [XLEN-1:0] last_data;

    assign write     = res_valid_i && res_reg_wr_i && (res_rd_i != 5'd0);
    assign rf_we_o   = write;
    assign rf_addr_o = res_rd_i;
    assign rf_data_o = res_data_i;

    // last write stays on the bypass through bubbles, so a stalled
    // memory op keeps the operand it was forwarded on entry
    always_ff @(posedge clk) begin
        if (reset_i) begin
            last_valid <= 1'b0;
        end else if (write) begin
            last_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            last_rd   <= res_rd_i;
            last_data <= res_data_i;
        end
    end

    assign fwd_valid_o = write || last_valid;
    assign fwd_rd_o    = write ? res_rd_i : last_rd;
    assign fwd_data_o  = write ? res_data_i : last_data;

    assign wb_valid_o = res_valid_i;
    assign wb_rd_o    = res_reg_wr_i ? res_rd_i : 5'd0;  // stores and no-ops show 0
    assign wb_data_o  = res_data_i;
    assign wb_pc_o    = res_pc_i;

endmodule

// File: design/rv32_core.sv
`timescale 1ns/100ps

module rv32_core
    import rv32_pkg::*;
(
    input  logic            clk,
    input  logic            reset_i,
    output logic [XLEN-1:0] imem_addr_o,
    input  logic [XLEN-1:0] imem_data_i,
    output logic            dmem_req_o,
    output logic            dmem_we_o,
    output logic [XLEN-1:0] dmem_addr_o,
    output logic [XLEN-1:0] dmem_wdata_o,
    input  logic            dmem_resp_i,
    input  logic [XLEN-1:0] dmem_rdata_i,
    output logic            wb_valid_o,
    output logic [4:0]      wb_rd_o,
    output logic [XLEN-1:0] wb_data_o,
    output logic [XLEN-1:0] wb_pc_o
);

    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            stall;

    // decode to execute
    logic            ex_valid;
    logic [4:0]      ex_rd;
    logic [4:0]      ex_rs1;
    logic [4:0]      ex_rs2;
    logic [XLEN-1:0] ex_a;
    logic [XLEN-1:0] ex_b;
    logic [XLEN-1:0] ex_imm;
    logic [3:0]      ex_alu_op;
    logic            ex_use_imm;
    logic            ex_mem_rd;
    logic            ex_mem_wr;
    logic            ex_reg_wr;
    logic [XLEN-1:0] ex_pc;

    // execute to result
    logic            res_valid;
    logic [4:0]      res_rd;
    logic            res_reg_wr;
    logic [XLEN-1:0] res_data;
    logic [XLEN-1:0] res_pc;

    logic            fwd_valid;
    logic [4:0]      fwd_rd;
    logic [XLEN-1:0] fwd_data;
    logic            rf_we;
    logic [4:0]      rf_addr;
    logic [XLEN-1:0] rf_data;

    decode_stage u_decode (
        .clk          (clk),
        .reset_i      (reset_i),
        .stall_i      (stall),
        .imem_data_i  (imem_data_i),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .imem_addr_o  (imem_addr_o),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .ex_valid_o   (ex_valid),
        .ex_rd_o      (ex_rd),
        .ex_rs1_o     (ex_rs1),
        .ex_rs2_o     (ex_rs2),
        .ex_a_o       (ex_a),
        .ex_b_o       (ex_b),
        .ex_imm_o     (ex_imm),
        .ex_alu_op_o  (ex_alu_op),
        .ex_use_imm_o (ex_use_imm),
        .ex_mem_rd_o  (ex_mem_rd),
        .ex_mem_wr_o  (ex_mem_wr),
        .ex_reg_wr_o  (ex_reg_wr),
        .ex_pc_o      (ex_pc)
    );

    register_file u_regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we),
        .rd_addr_i  (rf_addr),
        .rd_data_i  (rf_data)
    );

    execute_stage u_execute (
        .clk          (clk),
        .reset_i      (reset_i),
        .ex_valid_i   (ex_valid),
        .ex_rd_i      (ex_rd),
        .ex_rs1_i     (ex_rs1),
        .ex_rs2_i     (ex_rs2),
        .ex_a_i       (ex_a),
        .ex_b_i       (ex_b),
        .ex_imm_i     (ex_imm),
        .ex_alu_op_i  (ex_alu_op),
        .ex_use_imm_i (ex_use_imm),
        .ex_mem_rd_i  (ex_mem_rd),
        .ex_mem_wr_i  (ex_mem_wr),
        .ex_reg_wr_i  (ex_reg_wr),
        .ex_pc_i      (ex_pc),
        .fwd_valid_i  (fwd_valid),
        .fwd_rd_i     (fwd_rd),
        .fwd_data_i   (fwd_data),
        .dmem_resp_i  (dmem_resp_i),
        .dmem_rdata_i (dmem_rdata_i),
        .stall_o      (stall),
        .dmem_req_o   (dmem_req_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .res_valid_o  (res_valid),
        .res_rd_o     (res_rd),
        .res_reg_wr_o (res_reg_wr),
        .res_data_o   (res_data),
        .res_pc_o     (res_pc)
    );

    result_stage u_result (
        .clk          (clk),
        .reset_i      (reset_i),
        .res_valid_i  (res_valid),
        .res_rd_i     (res_rd),
        .res_reg_wr_i (res_reg_wr),
        .res_data_i   (res_data),
        .res_pc_i     (res_pc),
        .rf_we_o      (rf_we),
        .rf_addr_o    (rf_addr),
        .rf_data_o    (rf_data),
        .fwd_valid_o  (fwd_valid),
        .fwd_rd_o     (fwd_rd),
        .fwd_data_o   (fwd_data),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o),
        .wb_pc_o      (wb_pc_o)
    );

endmodule

// File: design/rv32_pkg.sv
package rv32_pkg;

    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;  // first fetch address

    // major opcodes
    localparam logic [6:0] OP_REG   = 7'b0110011;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    // funct3 for register and immediate ALU ops
    localparam logic [2:0] F3_ADD  = 3'b000;  // add / sub
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // srl / sra
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // internal ALU operation codes
    localparam logic [3:0] ALU_ADD   = 4'd0;
    localparam logic [3:0] ALU_SUB   = 4'd1;
    localparam logic [3:0] ALU_AND   = 4'd2;
    localparam logic [3:0] ALU_OR    = 4'd3;
    localparam logic [3:0] ALU_XOR   = 4'd4;
    localparam logic [3:0] ALU_SLT   = 4'd5;
    localparam logic [3:0] ALU_SLTU  = 4'd6;
    localparam logic [3:0] ALU_SLL   = 4'd7;
    localparam logic [3:0] ALU_SRL   = 4'd8;
    localparam logic [3:0] ALU_SRA   = 4'd9;
    localparam logic [3:0] ALU_PASSB = 4'd10;  // lui

    // one instruction word, four decode views
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
    } rv32_instr_u;

endpackage

// File: files.f
design/rv32_pkg.sv
design/register_file.sv
design/decode_stage.sv
design/alu.sv
design/execute_stage.sv
design/result_stage.sv
design/rv32_core.sv
sim/clock_gen.sv
sim/core_tb.sv

// File: sim/clock_gen.sv
`timescale 1ns/100ps

module clock_gen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;  // 20 ns period
    end

    initial begin
        reset_o = 1'b1;
        repeat (8) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;  // released on a falling edge
    end

endmodule

// File: sim/core_tb.sv
`timescale 1ns/100ps

module core_tb
    import rv32_pkg::*;
;

    localparam int NUM_ENTRIES = 30;
    localparam int NUM_SEGS    = 4;
    localparam int RETIRE_WAIT = 40;  // cycles allowed between two retires

    logic            clk;
    logic            reset_i;
    logic [XLEN-1:0] imem_addr_o;
    logic [XLEN-1:0] imem_data_i;
    logic            dmem_req_o;
    logic            dmem_we_o;
    logic [XLEN-1:0] dmem_addr_o;
    logic [XLEN-1:0] dmem_wdata_o;
    logic            dmem_resp_i;
    logic [XLEN-1:0] dmem_rdata_i;
    logic            wb_valid_o;
    logic [4:0]      wb_rd_o;
    logic [XLEN-1:0] wb_data_o;
    logic [XLEN-1:0] wb_pc_o;

    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:63];
    logic [4:0]  exp_rd [0:NUM_ENTRIES-1];
    logic [31:0] exp_data [0:NUM_ENTRIES-1];
    bit          exp_chk [0:NUM_ENTRIES-1];  // data column valid
    int          retire_cyc [0:NUM_ENTRIES-1];
    int          seg_last [0:NUM_SEGS-1];
    string       seg_name [0:NUM_SEGS-1];
    int          n_prog;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          cyc;
    logic [31:0] rng_state;
    bit          mem_busy;
    int          mem_wait;
    logic        req_we;     // request as first seen
    logic [31:0] req_addr;
    logic [31:0] req_wdata;

    clock_gen u_clock (
        .clk_o   (clk),
        .reset_o (reset_i)
    );

    rv32_core DUT (
        .clk          (clk),
        .reset_i      (reset_i),
        .imem_addr_o  (imem_addr_o),
        .imem_data_i  (imem_data_i),
        .dmem_req_o   (dmem_req_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_resp_i  (dmem_resp_i),
        .dmem_rdata_i (dmem_rdata_i),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o),
        .wb_pc_o      (wb_pc_o)
    );

    assign imem_data_i = imem[imem_addr_o[7:2]];  // combinational fetch

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        rv32_instr_u w;
        w.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: OP_REG};
        return w;
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [11:0] imm,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        rv32_instr_u w;
        w.i = '{imm: imm, rs1: rs1, funct3: f3, rd: rd, opcode: op};
        return w;
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        rv32_instr_u w;
        w.s = '{imm_hi: imm[11:5], rs2: rs2, rs1: rs1, funct3: 3'b010,
                imm_lo: imm[4:0], opcode: OP_STORE};
        return w;
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [19:0] imm,
                                          input logic [4:0] rd);
        rv32_instr_u w;
        w.u = '{imm: imm, rd: rd, opcode: op};
        return w;
    endfunction

    // one program word with the retire it should produce
    task automatic add_entry(input logic [31:0] word, input logic [4:0] rd,
                             input logic [31:0] data, input bit chk);
        imem[n_prog]     = word;
        exp_rd[n_prog]   = rd;
        exp_data[n_prog] = data;
        exp_chk[n_prog]  = chk;
        n_prog++;
    endtask

    task automatic load_program();
        for (int k = 0; k < 64; k++) begin
            imem[k] = enc_i(OP_IMM, 12'h000, 5'd0, F3_ADD, 5'd0);  // nop
            dmem[k] = {16'hd0a0, 8'h00, k[5:0], 2'b00} ^ {k[5:0], 26'h0};
        end
        n_prog = 0;
        add_entry(enc_i(OP_IMM, 12'd5, 5'd0, F3_ADD, 5'd1), 5'd1, 32'h0000_0005, 1);
        add_entry(enc_i(OP_IMM, 12'hffd, 5'd0, F3_ADD, 5'd2), 5'd2, 32'hffff_fffd, 1);
        add_entry(enc_r(7'h00, 5'd2, 5'd1, F3_ADD, 5'd3), 5'd3, 32'h0000_0002, 1);
        add_entry(enc_r(7'h20, 5'd2, 5'd1, F3_ADD, 5'd4), 5'd4, 32'h0000_0008, 1);
        add_entry(enc_r(7'h00, 5'd1, 5'd2, F3_SLT, 5'd5), 5'd5, 32'h0000_0001, 1);
        add_entry(enc_r(7'h00, 5'd1, 5'd2, F3_SLTU, 5'd6), 5'd6, 32'h0000_0000, 1);
        add_entry(enc_i(OP_IMM, 12'h401, 5'd2, F3_SR, 5'd7), 5'd7, 32'hffff_fffe, 1);
        add_entry(enc_i(OP_IMM, 12'h004, 5'd2, F3_SR, 5'd8), 5'd8, 32'h0fff_ffff, 1);
        add_entry(enc_i(OP_IMM, 12'h003, 5'd1, F3_SLL, 5'd9), 5'd9, 32'h0000_0028, 1);
        add_entry(enc_r(7'h00, 5'd2, 5'd1, F3_XOR, 5'd10), 5'd10, 32'hffff_fff8, 1);
        add_entry(enc_r(7'h00, 5'd2, 5'd1, F3_OR, 5'd11), 5'd11, 32'hffff_fffd, 1);
        add_entry(enc_r(7'h00, 5'd2, 5'd1, F3_AND, 5'd12), 5'd12, 32'h0000_0005, 1);
        add_entry(enc_u(OP_LUI, 20'h12345, 5'd13), 5'd13, 32'h1234_5000, 1);
        add_entry(enc_u(OP_AUIPC, 20'h00001, 5'd14), 5'd14, 32'h0000_1034, 1);
        add_entry(enc_i(OP_IMM, 12'h678, 5'd13, F3_ADD, 5'd13), 5'd13, 32'h1234_5678, 1);
        add_entry(enc_i(OP_IMM, 12'd7, 5'd0, F3_ADD, 5'd0), 5'd0, 32'h0, 0);  // x0 write
        add_entry(enc_r(7'h00, 5'd1, 5'd0, F3_ADD, 5'd15), 5'd15, 32'h0000_0005, 1);
        add_entry(enc_i(OP_IMM, 12'h040, 5'd0, F3_ADD, 5'd16), 5'd16, 32'h0000_0040, 1);
        add_entry(enc_s(12'd4, 5'd13, 5'd16), 5'd0, 32'h0, 0);
        add_entry(enc_i(OP_LOAD, 12'd4, 5'd16, 3'b010, 5'd17), 5'd17, 32'h1234_5678, 1);
        add_entry(enc_r(7'h00, 5'd1, 5'd17, F3_ADD, 5'd18), 5'd18, 32'h1234_567d, 1);
        add_entry(enc_s(12'd0, 5'd18, 5'd16), 5'd0, 32'h0, 0);
        add_entry(enc_i(OP_LOAD, 12'd0, 5'd16, 3'b010, 5'd19), 5'd19, 32'h1234_567d, 1);
        add_entry(enc_i(OP_LOAD, 12'd4, 5'd16, 3'b010, 5'd20), 5'd20, 32'h1234_5678, 1);
        add_entry(enc_r(7'h00, 5'd20, 5'd19, F3_ADD, 5'd21), 5'd21, 32'h2468_acf5, 1);
        add_entry(enc_r(7'h20, 5'd13, 5'd21, F3_ADD, 5'd22), 5'd22, 32'h1234_567d, 1);
        add_entry(enc_i(OP_IMM, 12'hfff, 5'd0, F3_ADD, 5'd23), 5'd23, 32'hffff_ffff, 1);
        add_entry(enc_r(7'h00, 5'd1, 5'd23, F3_SR, 5'd24), 5'd24, 32'h07ff_ffff, 1);
        add_entry(enc_i(OP_IMM, 12'hffe, 5'd2, F3_SLT, 5'd25), 5'd25, 32'h0000_0001, 1);
        add_entry(enc_i(OP_IMM, 12'hfff, 5'd1, F3_SLTU, 5'd26), 5'd26, 32'h0000_0001, 1);
        seg_last = '{14, 16, 25, 29};
        seg_name = '{"alu and immediate", "x0 writes", "store and load", "tail ops"};
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
        end
    endtask

    // waits for the next retire and samples it mid-cycle
    task automatic wait_retire(input bit req_quiet, output int waited, output bit seen);
        waited = 0;
        seen   = 0;
        while (!seen && waited < RETIRE_WAIT) begin
            @(negedge clk);
            cyc++;
            waited++;
            if (wb_valid_o) begin
                seen = 1;
            end else if (req_quiet) begin
                check_value("dmem_req_o", dmem_req_o, 32'h0);
            end
        end
    endtask

    // data memory model with random response delay
    always @(negedge clk) begin
        dmem_resp_i = 1'b0;
        if (reset_i) begin
            mem_busy = 0;
        end else if (dmem_req_o) begin
            if (!mem_busy) begin
                mem_busy  = 1;
                req_we    = dmem_we_o;
                req_addr  = dmem_addr_o;
                req_wdata = dmem_wdata_o;
                rng_state = next_random(rng_state);
                mem_wait  = rng_state[1:0];  // 0 to 3 cycles
            end else begin
                // request must hold until the response
                check_value("dmem_we_o", dmem_we_o, req_we);
                check_value("dmem_addr_o", dmem_addr_o, req_addr);
                if (req_we) begin
                    check_value("dmem_wdata_o", dmem_wdata_o, req_wdata);
                end
            end
            if (mem_wait == 0) begin
                dmem_resp_i  = 1'b1;
                dmem_rdata_i = dmem[dmem_addr_o[7:2]];
                if (dmem_we_o) begin
                    dmem[dmem_addr_o[7:2]] = dmem_wdata_o;
                end
                mem_busy = 0;
            end else begin
                mem_wait--;
            end
        end
    end

    initial begin
        int waited;
        bit seen;
        int seg;
        int seg_err;
        int timing_err;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cyc          = 0;
        rng_state    = 32'h6e3b_a630;
        mem_busy     = 0;
        mem_wait     = 0;
        req_we       = 1'b0;
        req_addr     = '0;
        req_wdata    = '0;
        dmem_resp_i  = 1'b0;
        dmem_rdata_i = '0;
        load_program();

        seg_err = errors;
        waited  = 0;
        @(posedge clk);
        while (reset_i && waited < 20) begin
            @(negedge clk);
            check_value("wb_valid_o", wb_valid_o, 32'h0);
            check_value("dmem_req_o", dmem_req_o, 32'h0);
            @(posedge clk);
            waited++;
        end
        if (reset_i) begin
            $display("reset was never released");
            $display("Testbench failed");
            $finish;
        end

        seg        = 0;
        timing_err = errors;
        for (int i = 0; i < n_prog; i++) begin
            wait_retire(i == 0, waited, seen);
            if (!seen) begin
                $display("timeout: no retire within %0d cycles, expected pc %h",
                         RETIRE_WAIT, i * 4);
                $display("Testbench failed");
                $finish;
            end
            retire_cyc[i] = cyc;
            if (i == 0) begin
                check_value("first retire latency", waited, 32'd2);
                check_value("wb_pc_o", wb_pc_o, 32'h0);
                report_test("reset and first fetch", seg_err);
                seg_err = errors;
            end
            check_value("wb_pc_o", wb_pc_o, i * 4);
            check_value("wb_rd_o", wb_rd_o, exp_rd[i]);
            if (exp_chk[i]) begin
                check_value("wb_data_o", wb_data_o, exp_data[i]);
            end
            if (i > 0 && i <= 17) begin  // no memory op ahead of these
                check_value("retire gap", retire_cyc[i] - retire_cyc[i-1], 32'd1);
            end
            if (i == 17) begin
                report_test("back-to-back retire timing", timing_err);
            end
            if (i == seg_last[seg]) begin
                report_test(seg_name[seg], seg_err);
                seg_err = errors;
                seg++;
            end
        end

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
